// File: list.f
game_pkg.sv
sdram_pkg.sv
frac_cen.sv
video_timing.sv
prom_we.sv
sdram_mux.sv
game_top.sv
game_properties.sv
tb_game.sv

// File: Makefile
# Verilator build and run of the game core testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module tb_game -f list.f -o tb_game

# Fails unless the pass message shows up in the simulation output
run: compile
	@out=$$(./obj_dir/tb_game +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Done: no errors$$"

clean:
	rm -rf obj_dir

// File: tb_game.sv
// Testbench for game_top with a behavioral SDRAM controller.
// The controller answers with random delays. Read data is a fixed function
// of the word address. Program writes get an ack and no data_rdy.
// Raster timing and sync are checked over one full frame.
`timescale 1ns/1ns

module tb_game
    import game_pkg::*;
    import sdram_pkg::*;
;

    localparam int CN = CEN_N;
    localparam int CM = CEN_M;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL * CEN_M / CEN_N;
    // Twice the frame wait plus the handshake tests
    localparam int TIMEOUT = 2 * (FRAME_CYCLES + 600);

    logic                 VB = 1'b0;
    logic                 reset;
    logic                 downloading;
    logic [22:0]          ioctl_addr;
    logic [7:0]           ioctl_data;
    logic                 ioctl_wr;
    logic [SDRAM_AW-1:0]  prog_addr;
    logic [7:0]           prog_data;
    logic [1:0]           prog_mask;
    logic                 prog_we;
    logic                 cfg_we;
    logic [SLOTS-1:0]     slot_cs;
    logic [SLOTS-1:0]     slot_wr;
    logic [SDRAM_AW-1:0]  main_rom_addr;
    logic [SDRAM_AW-1:0]  ram_addr;
    logic [SDRAM_AW-1:0]  gfx_addr;
    logic [SDRAM_AW-1:0]  snd_addr;
    logic [SDRAM_WDW-1:0] ram_din;
    logic [1:0]           ram_wrmask;
    logic [SDRAM_RDW-1:0] slot_dout;
    logic [SLOTS-1:0]     slot_ok;
    logic                 sdram_req;
    logic                 sdram_ack = 1'b0;
    logic                 data_rdy = 1'b0;
    logic [SDRAM_RDW-1:0] data_read = '0;
    logic [SDRAM_AW-1:0]  sdram_addr;
    logic                 sdram_rnw;
    logic [SDRAM_WDW-1:0] data_write;
    logic [1:0]           sdram_wrmask;
    logic                 refresh_en;
    logic                 pxl_cen;
    logic                 LHBL;
    logic                 LVBL;
    logic                 HS;
    logic                 VS;

    integer seed = 91140;
    int     errors = 0;
    int     timing_errors = 0;
    int     cycles = 0;
    int     frames_done = 0;

    always #5 VB = ~VB;

    game_top game_top_inst (.*);

    function automatic logic [SDRAM_RDW-1:0] model_data(input logic [SDRAM_AW-1:0] a);
        return {~a[9:0], a};
    endfunction

    function automatic logic [SDRAM_AW-1:0] expected_addr(input int idx,
                                                          input logic [SDRAM_AW-1:0] a);
        logic [SDRAM_AW-1:0] base;
        case (idx)
            SLOT_MAIN_ROM: base = MAIN_ROM_OFFSET;
            SLOT_RAM:      base = RAM_OFFSET;
            SLOT_GFX:      base = GFX_OFFSET;
            default:       base = SOUND_OFFSET;
        endcase
        return base + a;
    endfunction

    // First requesting slot, counted from index zero
    function automatic int lowest_pending(input logic [SLOTS-1:0] pending);
        for (int i = 0; i < SLOTS; i++) begin
            if (pending[i]) begin
                return i;
            end
        end
        return 0;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else begin
            errors++;
            $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // SDRAM controller model
    logic [1:0]          m_state = 2'd0;
    logic [2:0]          m_wait = 3'd0;
    logic                m_prog = 1'b0;
    logic [SDRAM_AW-1:0] m_addr = '0;

    always @(posedge VB) begin
        sdram_ack <= 1'b0;
        data_rdy  <= 1'b0;
        if (reset) begin
            m_state <= 2'd0;
        end else begin
            case (m_state)
                2'd0: begin
                    if (sdram_req || (prog_we && downloading)) begin
                        m_wait  <= 3'($random(seed) & 3);
                        m_state <= 2'd1;
                    end
                end
                2'd1: begin
                    if (m_wait == 3'd0) begin
                        sdram_ack <= 1'b1;
                        m_prog    <= !sdram_req;
                        m_addr    <= sdram_addr;
                        m_wait    <= 3'($random(seed) & 3);
                        m_state   <= 2'd2;
                    end else begin
                        m_wait <= m_wait - 3'd1;
                    end
                end
                default: begin
                    if (m_prog) begin
                        m_state <= 2'd0;
                    end else if (m_wait == 3'd0) begin
                        data_rdy  <= 1'b1;
                        data_read <= model_data(m_addr);
                        m_state   <= 2'd0;
                    end else begin
                        m_wait <= m_wait - 3'd1;
                    end
                end
            endcase
        end
    end

    task automatic rom_byte(input logic [22:0] a, input logic [7:0] d);
        @(posedge VB);
        ioctl_addr <= a;
        ioctl_data <= d;
        ioctl_wr   <= 1'b1;
        @(posedge VB);
        ioctl_wr <= 1'b0;
        @(negedge VB);
        check_value("rom prog_we", 32'd1, 32'(prog_we));
        check_value("rom prog_addr", 32'(a[22:1]), 32'(prog_addr));
        check_value("rom prog_data", 32'(d), 32'(prog_data));
        check_value("rom prog_mask", a[0] ? 32'h1 : 32'h2, 32'(prog_mask));
        while (!sdram_ack) begin
            @(negedge VB);
            check_value("rom prog_we held", 32'd1, 32'(prog_we));
        end
        @(negedge VB);
        check_value("rom prog_we release", 32'd0, 32'(prog_we));
    endtask

    task automatic cfg_byte(input logic [22:0] a, input logic [7:0] d);
        @(posedge VB);
        ioctl_addr <= a;
        ioctl_data <= d;
        ioctl_wr   <= 1'b1;
        @(posedge VB);
        ioctl_wr <= 1'b0;
        @(negedge VB);
        check_value("cfg cfg_we", 32'd1, 32'(cfg_we));
        check_value("cfg prog_data", 32'(d), 32'(prog_data));
        check_value("cfg prog_we", 32'd0, 32'(prog_we));
        repeat (3) begin
            @(negedge VB);
            check_value("cfg single pulse", 32'd0, 32'(cfg_we));
            check_value("cfg no prog_we", 32'd0, 32'(prog_we));
        end
    endtask

    // Raise the slots in mask together and follow each grant to its ok
    task automatic serve_group(input string name, input logic [SLOTS-1:0] mask,
                               input int hold);
        logic [SDRAM_AW-1:0] a [SLOTS];
        logic [SLOTS-1:0]    seen;
        logic                prev_req;
        int                  nxt;
        for (int i = 0; i < SLOTS; i++) begin
            a[i] = SDRAM_AW'($random(seed));
        end
        @(posedge VB);
        main_rom_addr <= a[SLOT_MAIN_ROM];
        ram_addr      <= a[SLOT_RAM];
        gfx_addr      <= a[SLOT_GFX];
        snd_addr      <= a[SLOT_SND];
        slot_wr       <= '0;
        slot_cs       <= mask;
        if (hold > 0) begin
            downloading <= 1'b1;
        end
        repeat (hold) begin
            @(negedge VB);
            check_value({name, " no grant"}, 32'd0, 32'(sdram_req));
            check_value({name, " no ok"}, 32'd0, 32'(slot_ok));
            check_value({name, " no refresh"}, 32'd0, 32'(refresh_en));
        end
        if (hold > 0) begin
            @(posedge VB);
            downloading <= 1'b0;
        end
        seen = '0;
        prev_req = 1'b0;
        while (seen != mask) begin
            @(negedge VB);
            nxt = lowest_pending(mask & ~seen);
            if (sdram_req && !prev_req) begin
                check_value({name, " addr"}, 32'(expected_addr(nxt, a[nxt])), 32'(sdram_addr));
                check_value({name, " rnw"}, 32'd1, 32'(sdram_rnw));
            end
            prev_req = sdram_req;
            if (|slot_ok) begin
                check_value({name, " ok"}, 32'(4'b0001 << nxt), 32'(slot_ok));
                check_value({name, " dout"}, model_data(expected_addr(nxt, a[nxt])), slot_dout);
                seen[nxt] = 1'b1;
                @(posedge VB);
                slot_cs[nxt] <= 1'b0;
            end
        end
    endtask

    task automatic ram_write(input logic [SDRAM_AW-1:0] a, input logic [15:0] d,
                             input logic [1:0] m);
        @(posedge VB);
        ram_addr          <= a;
        ram_din           <= d;
        ram_wrmask        <= m;
        slot_wr[SLOT_RAM] <= 1'b1;
        slot_cs[SLOT_RAM] <= 1'b1;
        @(negedge VB);
        while (!sdram_ack) @(negedge VB);
        check_value("ram write rnw", 32'd0, 32'(sdram_rnw));
        check_value("ram write addr", 32'(expected_addr(SLOT_RAM, a)), 32'(sdram_addr));
        check_value("ram write data", 32'(d), 32'(data_write));
        check_value("ram write mask", 32'(m), 32'(sdram_wrmask));
        while (!slot_ok[SLOT_RAM]) @(negedge VB);
        @(posedge VB);
        slot_cs[SLOT_RAM] <= 1'b0;
        slot_wr[SLOT_RAM] <= 1'b0;
    endtask

    // Pixel enable, blanking lengths, sync placement and refresh gating
    logic [CM-1:0] cen_hist = '0;
    int            cen_seen = 0;
    logic          prev_lvbl = 1'b1;
    logic          saw_fall = 1'b0;
    int            low_count = 0;
    logic          prev_lhbl = 1'b1;
    logic          saw_hfall = 1'b0;
    int            hlow_count = 0;
    logic          prev_hs = 1'b0;
    logic          prev_vs = 1'b0;
    int            hs_count = 0;
    int            vs_count = 0;

    always @(negedge VB) begin
        if (!reset) begin
            cen_hist = {cen_hist[CM-2:0], pxl_cen};
            if (cen_seen < CM) cen_seen++;
            if (cen_seen == CM) begin
                assert ($countones(cen_hist) == CN)
                else begin
                    timing_errors++;
                    $display("ERROR pxl_cen window: expected %0d, actual %0d",
                             CN, $countones(cen_hist));
                end
            end
            // One line of horizontal blanking
            if (!LHBL && prev_lhbl) begin
                saw_hfall = 1'b1;
                hlow_count = 0;
                hs_count = 0;
            end
            if (!LHBL && pxl_cen) hlow_count++;
            if (HS && !prev_hs) hs_count++;
            if (LHBL && !prev_lhbl && saw_hfall) begin
                assert (hlow_count == H_TOTAL - H_VISIBLE)
                else begin
                    timing_errors++;
                    $display("ERROR LHBL low enables: expected %0d, actual %0d",
                             H_TOTAL - H_VISIBLE, hlow_count);
                end
                assert (hs_count == 1)
                else begin
                    timing_errors++;
                    $display("ERROR HS pulses per line: expected 1, actual %0d", hs_count);
                end
            end
            prev_lhbl = LHBL;
            prev_hs = HS;
            // Vertical blank of one frame
            if (!LVBL && prev_lvbl) begin
                saw_fall = 1'b1;
                low_count = 0;
                vs_count = 0;
            end
            if (!LVBL && pxl_cen) low_count++;
            if (VS && !prev_vs) vs_count++;
            if (LVBL && !prev_lvbl && saw_fall) begin
                frames_done++;
                assert (low_count == (V_TOTAL - V_VISIBLE) * H_TOTAL)
                else begin
                    timing_errors++;
                    $display("ERROR LVBL low enables: expected %0d, actual %0d",
                             (V_TOTAL - V_VISIBLE) * H_TOTAL, low_count);
                end
                assert (vs_count == 1)
                else begin
                    timing_errors++;
                    $display("ERROR VS pulses per frame: expected 1, actual %0d", vs_count);
                end
            end
            prev_lvbl = LVBL;
            prev_vs = VS;
            assert (!(HS && LHBL) && !(VS && LVBL))
            else begin
                timing_errors++;
                $display("A sync pulse appeared outside its blanking interval");
            end
            assert (!(refresh_en && (LVBL || sdram_req || downloading)))
            else begin
                timing_errors++;
                $display("Refresh enabled outside vblank or during a request or download");
            end
        end
    end

    always @(posedge VB) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("Timeout after %0d cycles, the tests did not complete", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        reset         = 1'b1;
        downloading   = 1'b0;
        ioctl_addr    = '0;
        ioctl_data    = '0;
        ioctl_wr      = 1'b0;
        slot_cs       = '0;
        slot_wr       = '0;
        main_rom_addr = '0;
        ram_addr      = '0;
        gfx_addr      = '0;
        snd_addr      = '0;
        ram_din       = '0;
        ram_wrmask    = 2'b11;
        repeat (4) @(posedge VB);
        reset <= 1'b0;

        @(posedge VB);
        downloading <= 1'b1;
        rom_byte(23'h00_1234, 8'hA5);
        rom_byte(23'h04_4321, 8'h3C);
        cfg_byte(CFG_START, 8'h81);
        cfg_byte(CFG_START + 23'd7, 8'h42);
        @(posedge VB);
        downloading <= 1'b0;

        for (int i = 0; i < SLOTS; i++) begin
            serve_group("slot read", 4'(4'b0001 << i), 0);
        end
        serve_group("priority all", 4'b1111, 0);
        serve_group("priority subset", 4'b1010, 0);
        serve_group("download hold", 4'b0111, 12);
        ram_write(22'h00_0123, 16'hBEEF, 2'b00);
        ram_write(22'h01_0456, 16'h1234, 2'b10);

        // Traffic inside vertical blank, where refresh is allowed
        while (LVBL) @(negedge VB);
        check_value("refresh idle vblank", 32'd1, 32'(refresh_en));
        serve_group("vblank read", 4'b0101, 0);
        serve_group("vblank hold", 4'b1001, 6);

        // A full vertical blank must have been measured
        while (frames_done < 1) @(negedge VB);

        $display("Errors: %0d checks, %0d timing, %0d assertions",
                 errors, timing_errors, game_top_inst.props_inst.fail_count);
        if (errors + timing_errors + game_top_inst.props_inst.fail_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: game_properties.sv
// Concurrent checks on the SDRAM and download handshakes of game_top.
// Attached with bind. Each assertion keeps its own failure count, and
// fail_count is their sum for the testbench's closing report.
`timescale 1ns/1ns

module game_properties
    import sdram_pkg::*;
(
    input logic             VB,
    input logic             reset,
    input logic             sdram_req,
    input logic             sdram_ack,
    input logic [SLOTS-1:0] slot_ok,
    input logic             prog_we,
    input logic             refresh_en
);

    int req_fails     = 0;
    int ok_len_fails  = 0;
    int prog_fails    = 0;
    int refresh_fails = 0;
    int fail_count;

    assign fail_count = req_fails + ok_len_fails + prog_fails + refresh_fails;

    // Request is held until the controller takes it
    req_hold: assert property (@(posedge VB) disable iff (reset)
        sdram_req && !sdram_ack |=> sdram_req)
    else begin
        req_fails++;
        $error("sdram_req dropped before sdram_ack");
    end

    ok_one_cycle: assert property (@(posedge VB) disable iff (reset)
        (|slot_ok) |=> !(|slot_ok))
    else begin
        ok_len_fails++;
        $error("slot_ok stayed high for more than one cycle");
    end

    prog_release: assert property (@(posedge VB) disable iff (reset)
        prog_we && sdram_ack |=> !prog_we)
    else begin
        prog_fails++;
        $error("prog_we did not fall after sdram_ack");
    end

    refresh_excl: assert property (@(posedge VB) disable iff (reset)
        !(refresh_en && sdram_req))
    else begin
        refresh_fails++;
        $error("refresh_en high during an SDRAM request");
    end

endmodule

bind game_top game_properties props_inst (
    .VB         (VB),
    .reset      (reset),
    .sdram_req  (sdram_req),
    .sdram_ack  (sdram_ack),
    .slot_ok    (slot_ok),
    .prog_we    (prog_we),
    .refresh_en (refresh_en)
);

// File: game_top.sv
// Memory sharing and timing core of the game.
// CPU, video renderer and sound live outside and reach SDRAM through the
// four client slots. The raster counters stay internal to this block.
// One sdram_ack serves both the download path and the arbiter, and the
// controller must serve prog_we only while downloading is high.
`timescale 1ns/1ns

module game_top
    import game_pkg::*;
    import sdram_pkg::*;
#(
    parameter int CEN_N     = game_pkg::CEN_N,
    parameter int CEN_M     = game_pkg::CEN_M,
    parameter int H_TOTAL   = game_pkg::H_TOTAL,
    parameter int H_VISIBLE = game_pkg::H_VISIBLE,
    parameter int V_TOTAL   = game_pkg::V_TOTAL,
    parameter int V_VISIBLE = game_pkg::V_VISIBLE
) (
    input  logic                 VB,
    input  logic                 reset,
    // Download
    input  logic                 downloading,
    input  logic [22:0]          ioctl_addr,
    input  logic [7:0]           ioctl_data,
    input  logic                 ioctl_wr,
    output logic [SDRAM_AW-1:0]  prog_addr,
    output logic [7:0]           prog_data,
    output logic [1:0]           prog_mask,
    output logic                 prog_we,
    output logic                 cfg_we,
    // Client slots
    input  logic [SLOTS-1:0]     slot_cs,
    input  logic [SLOTS-1:0]     slot_wr,
    input  logic [SDRAM_AW-1:0]  main_rom_addr,
    input  logic [SDRAM_AW-1:0]  ram_addr,
    input  logic [SDRAM_AW-1:0]  gfx_addr,
    input  logic [SDRAM_AW-1:0]  snd_addr,
    input  logic [SDRAM_WDW-1:0] ram_din,
    input  logic [1:0]           ram_wrmask,
    output logic [SDRAM_RDW-1:0] slot_dout,
    output logic [SLOTS-1:0]     slot_ok,
    // SDRAM controller
    output logic                 sdram_req,
    input  logic                 sdram_ack,
    input  logic                 data_rdy,
    input  logic [SDRAM_RDW-1:0] data_read,
    output logic [SDRAM_AW-1:0]  sdram_addr,
    output logic                 sdram_rnw,
    output logic [SDRAM_WDW-1:0] data_write,
    output logic [1:0]           sdram_wrmask,
    output logic                 refresh_en,
    // Video
    output logic                 pxl_cen,
    output logic                 LHBL,
    output logic                 LVBL,
    output logic                 HS,
    output logic                 VS
);

    logic hblank;
    logic vblank;

    // Active low blanking for the video side
    assign LHBL = ~hblank;
    assign LVBL = ~vblank;

    frac_cen #(
        .N (CEN_N),
        .M (CEN_M)
    ) frac_cen_inst (
        .VB    (VB),
        .reset (reset),
        .cen   (pxl_cen)
    );

    video_timing #(
        .H_TOTAL   (H_TOTAL),
        .H_VISIBLE (H_VISIBLE),
        .V_TOTAL   (V_TOTAL),
        .V_VISIBLE (V_VISIBLE)
    ) video_timing_inst (
        .VB     (VB),
        .reset  (reset),
        .cen    (pxl_cen),
        .hdump  (),
        .vdump  (),
        .hblank (hblank),
        .vblank (vblank),
        .HS     (HS),
        .VS     (VS)
    );

    prom_we prom_we_inst (
        .VB          (VB),
        .reset       (reset),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_data  (ioctl_data),
        .ioctl_wr    (ioctl_wr),
        .sdram_ack   (sdram_ack),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_mask   (prog_mask),
        .prog_we     (prog_we),
        .cfg_we      (cfg_we)
    );

    sdram_mux sdram_mux_inst (
        .VB            (VB),
        .reset         (reset),
        .vblank        (vblank),
        .downloading   (downloading),
        .slot_cs       (slot_cs),
        .slot_wr       (slot_wr),
        .main_rom_addr (main_rom_addr),
        .ram_addr      (ram_addr),
        .gfx_addr      (gfx_addr),
        .snd_addr      (snd_addr),
        .ram_din       (ram_din),
        .ram_wrmask    (ram_wrmask),
        .slot_dout     (slot_dout),
        .slot_ok       (slot_ok),
        .sdram_req     (sdram_req),
        .sdram_ack     (sdram_ack),
        .data_rdy      (data_rdy),
        .data_read     (data_read),
        .sdram_addr    (sdram_addr),
        .sdram_rnw     (sdram_rnw),
        .data_write    (data_write),
        .sdram_wrmask  (sdram_wrmask),
        .refresh_en    (refresh_en)
    );

endmodule

// File: sdram_mux.sv
// Fixed priority arbiter for the shared SDRAM port.
// The lowest pending slot wins. One access is in flight at a time.
// Slots hold cs, wr and address until their ok pulse. Only the RAM slot
// writes. No slot is served while downloading, and refresh is allowed
// only in vertical blanking with the arbiter idle.
`timescale 1ns/1ns

module sdram_mux
    import game_pkg::*;
    import sdram_pkg::*;
(
    input  logic                 VB,
    input  logic                 reset,
    input  logic                 vblank,
    input  logic                 downloading,
    // Client slots
    input  logic [SLOTS-1:0]     slot_cs,
    input  logic [SLOTS-1:0]     slot_wr,
    input  logic [SDRAM_AW-1:0]  main_rom_addr,
    input  logic [SDRAM_AW-1:0]  ram_addr,
    input  logic [SDRAM_AW-1:0]  gfx_addr,
    input  logic [SDRAM_AW-1:0]  snd_addr,
    input  logic [SDRAM_WDW-1:0] ram_din,
    input  logic [1:0]           ram_wrmask,
    output logic [SDRAM_RDW-1:0] slot_dout,
    output logic [SLOTS-1:0]     slot_ok,
    // SDRAM controller
    output logic                 sdram_req,
    input  logic                 sdram_ack,
    input  logic                 data_rdy,
    input  logic [SDRAM_RDW-1:0] data_read,
    output logic [SDRAM_AW-1:0]  sdram_addr,
    output logic                 sdram_rnw,
    output logic [SDRAM_WDW-1:0] data_write,
    output logic [1:0]           sdram_wrmask,
    output logic                 refresh_en
);

    localparam int SW = $clog2(SLOTS);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_ACK  = 2'd1;
    localparam logic [1:0] ST_DATA = 2'd2;

    logic [1:0]          state;
    logic [SW-1:0]       pick;
    logic [SW-1:0]       grant;
    logic [SDRAM_AW-1:0] pick_addr;
    logic                pick_wr;
    logic                can_pick;

    // Lowest set index wins
    always_comb begin
        pick = '0;
        for (int i = SLOTS - 1; i >= 0; i--) begin
            if (slot_cs[i]) begin
                pick = SW'(i);
            end
        end
    end

    // Region offset plus the address inside the region
    always_comb begin
        case (int'(pick))
            SLOT_MAIN_ROM: pick_addr = MAIN_ROM_OFFSET + main_rom_addr;
            SLOT_RAM:      pick_addr = RAM_OFFSET + ram_addr;
            SLOT_GFX:      pick_addr = GFX_OFFSET + gfx_addr;
            SLOT_SND:      pick_addr = SOUND_OFFSET + snd_addr;
            default:       pick_addr = '0;
        endcase
    end

    assign pick_wr = slot_wr[pick] && (int'(pick) == SLOT_RAM);

    // Skip the ok cycle, the client still holds cs then
    assign can_pick = (|slot_cs) && !downloading && !(|slot_ok);

    assign refresh_en = vblank && (state == ST_IDLE) && !downloading;

    always_ff @(posedge VB) begin
        if (reset) begin
            state     <= ST_IDLE;
            sdram_req <= 1'b0;
            sdram_rnw <= 1'b1;
            slot_ok   <= '0;
        end else begin
            slot_ok <= '0;
            case (state)
                ST_IDLE: begin
                    if (can_pick) begin
                        sdram_req <= 1'b1;
                        sdram_rnw <= !pick_wr;
                        state     <= ST_ACK;
                    end
                end
                ST_ACK: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (data_rdy) begin
                        slot_ok[grant] <= 1'b1;
                        sdram_rnw      <= 1'b1;
                        state          <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Request payload and returned data
    always_ff @(posedge VB) begin
        if (state == ST_IDLE && can_pick) begin
            grant        <= pick;
            sdram_addr   <= pick_addr;
            data_write   <= ram_din;
            sdram_wrmask <= pick_wr ? ram_wrmask : 2'b11;
        end
        if (state == ST_DATA && data_rdy) begin
            slot_dout <= data_read;
        end
    end

endmodule

// File: prom_we.sv
// Turns the serial download into SDRAM program writes.
// ROM bytes become masked 16-bit word writes at half the byte address.
// Bytes at or above CFG_START only raise a one-cycle cfg_we with the byte
// on prog_data. A new byte must not arrive while prog_we is still high.
`timescale 1ns/1ns

module prom_we
    import game_pkg::*;
    import sdram_pkg::*;
(
    input  logic                VB,
    input  logic                reset,
    input  logic                downloading,
    input  logic [22:0]         ioctl_addr,
    input  logic [7:0]          ioctl_data,
    input  logic                ioctl_wr,
    input  logic                sdram_ack,
    output logic [SDRAM_AW-1:0] prog_addr,
    output logic [7:0]          prog_data,
    output logic [1:0]          prog_mask,
    output logic                prog_we,
    output logic                cfg_we
);

    logic byte_in;
    logic is_cfg;

    assign byte_in = ioctl_wr && downloading;
    assign is_cfg  = (ioctl_addr >= CFG_START);

    // Control flags
    always_ff @(posedge VB) begin
        if (reset) begin
            prog_we <= 1'b0;
            cfg_we  <= 1'b0;
        end else begin
            cfg_we <= byte_in && is_cfg;
            if (byte_in && !is_cfg) begin
                prog_we <= 1'b1;
            end else if (sdram_ack) begin
                // Controller took the write
                prog_we <= 1'b0;
            end
        end
    end

    // Payload follows every accepted byte
    always_ff @(posedge VB) begin
        if (byte_in) begin
            prog_data <= ioctl_data;
            prog_addr <= ioctl_addr[22:1];
            // Active low mask, the addressed byte only
            prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;
        end
    end

endmodule

// File: video_timing.sv
// Raster counters with blanking and sync, advanced by the pixel enable.
// Totals must fit the 9-bit counters. Visible area starts at count zero.
// Sync pulses sit in the middle of each blanking interval with a width of
// a quarter of the blanking, at least one pixel or line.
`timescale 1ns/1ns

module video_timing #(
    parameter int H_TOTAL   = 48,
    parameter int H_VISIBLE = 32,
    parameter int V_TOTAL   = 24,
    parameter int V_VISIBLE = 16
) (
    input  logic       VB,
    input  logic       reset,
    input  logic       cen,
    output logic [8:0] hdump,
    output logic [8:0] vdump,
    output logic       hblank,
    output logic       vblank,
    output logic       HS,
    output logic       VS
);

    localparam int H_BLANK = H_TOTAL - H_VISIBLE;
    localparam int V_BLANK = V_TOTAL - V_VISIBLE;
    localparam int H_SW    = (H_BLANK > 3) ? H_BLANK / 4 : 1;
    localparam int V_SW    = (V_BLANK > 3) ? V_BLANK / 4 : 1;
    localparam int H_SS    = H_VISIBLE + (H_BLANK - H_SW) / 2;
    localparam int V_SS    = V_VISIBLE + (V_BLANK - V_SW) / 2;

    logic [8:0] h_next;
    logic [8:0] v_next;
    logic       h_wrap;

    assign h_wrap = (hdump == 9'(H_TOTAL - 1));
    assign h_next = h_wrap ? 9'd0 : hdump + 9'd1;

    always_comb begin
        v_next = vdump;
        if (h_wrap) begin
            v_next = (vdump == 9'(V_TOTAL - 1)) ? 9'd0 : vdump + 9'd1;
        end
    end

    // Flags are derived from the next count so they line up with the counters
    always_ff @(posedge VB) begin
        if (reset) begin
            hdump  <= 9'd0;
            vdump  <= 9'd0;
            hblank <= 1'b0;
            vblank <= 1'b0;
            HS     <= 1'b0;
            VS     <= 1'b0;
        end else if (cen) begin
            hdump  <= h_next;
            vdump  <= v_next;
            hblank <= (h_next >= 9'(H_VISIBLE));
            vblank <= (v_next >= 9'(V_VISIBLE));
            HS     <= (h_next >= 9'(H_SS)) && (h_next < 9'(H_SS + H_SW));
            VS     <= (v_next >= 9'(V_SS)) && (v_next < 9'(V_SS + V_SW));
        end
    end

endmodule

// File: frac_cen.sv
// Fractional clock enable. Gives N one-cycle pulses in every M clocks.
// N must not exceed M. Pulses are spread as evenly as the ratio allows.
// The first pulse follows the first clock after reset.
`timescale 1ns/1ns

module frac_cen #(
    parameter int N = 1,
    parameter int M = 4
) (
    input  logic VB,
    input  logic reset,
    output logic cen
);

    // One extra bit so that acc + N never overflows
    localparam int W = $clog2(M) + 1;

    logic [W-1:0] acc;
    logic [W-1:0] sum;

    assign sum = acc + W'(N);

    always_ff @(posedge VB) begin
        if (reset) begin
            // Preloaded so the very first add wraps
            acc <= W'(M - N);
            cen <= 1'b0;
        end else if (sum >= W'(M)) begin
            acc <= sum - W'(M);
            cen <= 1'b1;
        end else begin
            acc <= sum;
            cen <= 1'b0;
        end
    end

endmodule

// File: sdram_pkg.sv
// Slot numbering and bus widths of the shared SDRAM port.
// A lower slot index wins arbitration over a higher one.
// Only the RAM slot is allowed to write.
package sdram_pkg;

    // Number of clients on the arbiter
    localparam int SLOTS = 4;

    // Slot indices, highest priority first
    localparam int SLOT_MAIN_ROM = 0;
    localparam int SLOT_RAM      = 1;
    localparam int SLOT_GFX      = 2;
    localparam int SLOT_SND      = 3;

    // Word address width of the controller
    localparam int SDRAM_AW = 22;

    // Reads return two words at once
    localparam int SDRAM_RDW = 32;

    // Writes carry a single 16-bit word with a byte mask
    localparam int SDRAM_WDW = 16;

endpackage

// File: game_pkg.sv
// Memory map and raster constants of the game.
// Offsets are 16-bit word addresses inside the 22-bit SDRAM space.
// CFG_START is a download byte address. Bytes from there on are configuration.
// Raster sizes are kept small so simulations stay short. A real board
// overrides them at the top level.
package game_pkg;

    // Region starts in SDRAM, word addressed
    localparam logic [21:0] MAIN_ROM_OFFSET = 22'h00_0000;
    localparam logic [21:0] SOUND_OFFSET    = 22'h08_0000;
    localparam logic [21:0] GFX_OFFSET      = 22'h0A_0000;
    localparam logic [21:0] RAM_OFFSET      = 22'h3A_8000;

    // First byte of the configuration block in the download stream
    localparam logic [22:0] CFG_START = 23'h78_0000;

    // Pixel enable ratio, N pulses every M clocks
    localparam int CEN_N = 1;
    localparam int CEN_M = 4;

    // Raster sizes in pixels and lines
    localparam int H_TOTAL   = 48;
    localparam int H_VISIBLE = 32;
    localparam int V_TOTAL   = 24;
    localparam int V_VISIBLE = 16;

endpackage
